// ==== cpc_ram_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512K RAM expansion shared definitions
// Bank select layout, mapping scheme opcodes, write-cycle FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpc_ram_pkg;

  // Block switching schemes, value of data bits 2:0 on a bank select write
  typedef enum logic [2:0] {
    SCH_BASE     = 3'b000,  // Base RAM only, shadow writes to top quadrant
    SCH_HI_BLOCK = 3'b001,  // Top quadrant from expansion block 3
    SCH_FLAT     = 3'b010,  // Whole 64K from expansion bank
    SCH_C3       = 3'b011,  // Top quadrant block 3, 0x4000 remapped to shadow block 3
    SCH_LO_B0    = 3'b100,  // Quadrant 1 from block 0
    SCH_LO_B1    = 3'b101,
    SCH_LO_B2    = 3'b110,
    SCH_LO_B3    = 3'b111   // Quadrant 1 from block 3
  } map_scheme_e;

  // Write cycle tracker, gray coded
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    T1   = 2'b01,  // Wait here while READY is low
    T2   = 2'b11,
    WEND = 2'b10   // Same as IDLE, last cycle of a write
  } wr_state_e;

  // Bank select register contents, data bits 5:0 of the I/O write
  typedef struct packed {
    logic [2:0]  bank;    // One of eight 64K banks
    map_scheme_e scheme;  // Block switching scheme in that bank
  } bank_cfg_t;

  // Bank that holds the shadow copy of base RAM
  localparam logic [2:0] SHADOW_BANK = 3'd7;

  // Data bits 7:6 marking a bank select write
  localparam logic [1:0] BANK_TAG = 2'b11;

  // Width of the high RAM address, bank plus block
  localparam int RAM_ADR_W = 5;

endpackage

// ==== bank_select_reg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank select register
// Decodes I/O writes with A15 low and tag 11 in bits 7:6, holds bank and scheme
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bank_select_reg (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   iorq_b,
  input  logic                   wr_b,
  input  logic                   adr15,
  input  logic [7:0]             data,
  output cpc_ram_pkg::bank_cfg_t bank_cfg
);

  import cpc_ram_pkg::*;

  logic bank_wr;  // I/O write aimed at the bank register

  // Gate array shares the port range, A15 low plus tag picks this register
  assign bank_wr = !iorq_b && !wr_b && !adr15 && (data[7:6] == BANK_TAG);

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bank_cfg.bank   <= 3'd0;
      bank_cfg.scheme <= SCH_BASE;  // Power up with base RAM only
    end else if (bank_wr) begin
      bank_cfg.bank   <= data[5:3];                  // ccc
      bank_cfg.scheme <= map_scheme_e'(data[2:0]);   // bbb
    end
  end

endmodule

// ==== write_cycle_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory write cycle tracker
// Finds Z80 memory cycle starts, latches A15, times writes against READY
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module write_cycle_ctrl (
  input  logic clk,
  input  logic reset_b,
  input  logic mreq_b,
  input  logic rfsh_b,
  input  logic rd_b,
  input  logic ready,
  input  logic adr15,
  output logic mem_act,
  output logic cyc_start,
  output logic mwr_cyc,
  output logic adr15_lat
);

  import cpc_ram_pkg::*;

  logic      mreq_b_q;   // MREQ* one edge back
  logic      ready_q;    // Sampled READY
  logic      adr15_q;    // A15 held from the last start
  wr_state_e state_q;
  wr_state_e state_nxt;

  // Real memory access, refresh cycles excluded
  assign mem_act = !mreq_b && rfsh_b;

  // MREQ* falling with RD* high, so a write (or a read still to come)
  assign cyc_start = !mreq_b && mreq_b_q && rfsh_b && rd_b;

  // Live A15 on the start cycle, held value after that
  assign adr15_lat = cyc_start ? adr15 : adr15_q;

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mreq_b_q <= 1'b1;
      ready_q  <= 1'b1;  // Not stalled out of reset
      adr15_q  <= 1'b0;
    end else begin
      mreq_b_q <= mreq_b;
      ready_q  <= ready;
      if (cyc_start)
        adr15_q <= adr15;  // Hold A15 for the rest of the cycle
    end
  end

  // Next state
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE:    state_nxt = cyc_start ? T1 : IDLE;
      T1:      state_nxt = ready_q ? T2 : T1;  // Stretch while wait states last
      T2:      state_nxt = WEND;
      WEND:    state_nxt = cyc_start ? T1 : IDLE;  // Back to back cycles allowed
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_b)
      state_q <= IDLE;
    else
      state_q <= state_nxt;
  end

  // Write window, covers the wait states and one more cycle
  assign mwr_cyc = (state_q == T1) || (state_q == T2);

endmodule

// ==== ram_mapper.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Partial shadow address mapper, 464 overdrive always on
// Picks expansion RAM select, high address and A15 overdrive per quadrant
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ram_mapper (
  input  cpc_ram_pkg::bank_cfg_t             bank_cfg,
  input  logic                               adr15_lat,
  input  logic                               adr14,
  input  logic                               wr_b,
  input  logic                               mwr_cyc,
  output logic                               ramcs_sel_b,
  output logic [cpc_ram_pkg::RAM_ADR_W-1:0]  ramadrhi,
  output logic                               exp_ram,
  output logic                               adr15_force
);

  import cpc_ram_pkg::*;

  logic [1:0] quad;         // Address quadrant, 16K each
  logic [2:0] eff_bank;     // Bank after shadow aliasing
  logic [2:0] scheme_code;  // Raw scheme bits
  logic       hit;          // Access goes to the expansion bank
  logic       c3_remap;     // Mode C3 read of 0x4000 from shadow block 3
  logic [1:0] blk;          // Expansion block on a hit
  logic       shadow_wr_b;  // Write to top quadrant, copied into shadow bank

  assign quad        = {adr15_lat, adr14};
  assign scheme_code = bank_cfg.scheme;

  // Bank 7 holds the shadow copy, so it aliases onto bank 6
  assign eff_bank = (bank_cfg.bank == SHADOW_BANK) ? {bank_cfg.bank[2:1], 1'b0}
                                                   : bank_cfg.bank;

  assign shadow_wr_b = !(!wr_b && (quad == 2'b11));

  // Scheme decode
  always_comb begin
    hit      = 1'b0;
    c3_remap = 1'b0;
    blk      = quad;
    case (bank_cfg.scheme)
      SCH_BASE: ;  // Nothing from the expansion
      SCH_HI_BLOCK: begin
        hit = (quad == 2'b11);
        blk = 2'b11;
      end
      SCH_FLAT:     hit = 1'b1;  // Block follows the quadrant
      SCH_C3: begin
        hit      = (quad == 2'b11);
        c3_remap = (quad == 2'b01);
        blk      = 2'b11;
      end
      SCH_LO_B0, SCH_LO_B1, SCH_LO_B2, SCH_LO_B3: begin
        hit = (quad == 2'b01);
        blk = scheme_code[1:0];  // Low scheme bits pick the block
      end
      default: ;
    endcase
  end

  // Select and high address
  always_comb begin
    if (hit) begin
      exp_ram     = 1'b1;
      ramcs_sel_b = 1'b0;
      ramadrhi    = {eff_bank, blk};
    end else if (c3_remap) begin
      exp_ram     = 1'b0;  // Shadow copy of base block 3, not an expansion hit
      ramcs_sel_b = 1'b0;
      ramadrhi    = {SHADOW_BANK, 2'b11};
    end else begin
      exp_ram     = 1'b0;
      ramcs_sel_b = shadow_wr_b;           // Only top quadrant writes reach the shadow
      ramadrhi    = {SHADOW_BANK, quad};
    end
  end

  // Mode C3 write to 0x4000 lands at 0xC000 in base RAM on a 464
  assign adr15_force = (bank_cfg.scheme == SCH_C3) && !adr15_lat && adr14 && mwr_cyc;

endmodule

// ==== ram512k_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512K RAM expansion top level
// Bank register, write tracker and mapper, plus the RAM and force strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ram512k_top (
  input  logic                               clk,
  input  logic                               reset_b,
  input  logic                               mreq_b,
  input  logic                               iorq_b,
  input  logic                               rfsh_b,
  input  logic                               wr_b,
  input  logic                               rd_b,
  input  logic                               ramrd_b,
  input  logic                               ready,
  input  logic                               adr15,
  input  logic                               adr14,
  input  logic [7:0]                         data,
  output logic                               ramdis,
  output logic                               ramcs_b,
  output logic [cpc_ram_pkg::RAM_ADR_W-1:0]  ramadrhi,
  output logic                               ramoe_b,
  output logic                               ramwe_b,
  output logic                               rd_force,
  output logic                               adr15_force
);

  import cpc_ram_pkg::*;

  bank_cfg_t bank_cfg;     // Current bank and scheme
  logic      mem_act;      // Memory access, no refresh
  logic      mwr_cyc;      // Write window
  logic      adr15_lat;    // A15 for this cycle
  logic      ramcs_sel_b;  // Mapper wants the expansion RAM
  logic      exp_ram;      // Expansion bank hit

  bank_select_reg u_bank_select_reg (
    .clk      (clk),
    .reset_b  (reset_b),
    .iorq_b   (iorq_b),
    .wr_b     (wr_b),
    .adr15    (adr15),
    .data     (data),
    .bank_cfg (bank_cfg)
  );

  write_cycle_ctrl u_write_cycle_ctrl (
    .clk       (clk),
    .reset_b   (reset_b),
    .mreq_b    (mreq_b),
    .rfsh_b    (rfsh_b),
    .rd_b      (rd_b),
    .ready     (ready),
    .adr15     (adr15),
    .mem_act   (mem_act),
    .cyc_start (),
    .mwr_cyc   (mwr_cyc),
    .adr15_lat (adr15_lat)
  );

  ram_mapper u_ram_mapper (
    .bank_cfg    (bank_cfg),
    .adr15_lat   (adr15_lat),
    .adr14       (adr14),
    .wr_b        (wr_b),
    .mwr_cyc     (mwr_cyc),
    .ramcs_sel_b (ramcs_sel_b),
    .ramadrhi    (ramadrhi),
    .exp_ram     (exp_ram),
    .adr15_force (adr15_force)
  );

  assign ramwe_b  = wr_b;                    // Write strobe straight from the CPU
  assign ramoe_b  = ramrd_b || mwr_cyc;      // No output drive during a write
  assign rd_force = exp_ram && mwr_cyc;      // Hold off base RAM on expansion writes
  assign ramdis   = !ramcs_sel_b;            // Internal RAM off whenever we answer
  assign ramcs_b  = ramcs_sel_b || !mem_act;

endmodule

// ==== tb_ram512k.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 512K RAM expansion testbench
// Directed Z80 bus cycles checked against a reference mapping model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ram512k;

  import cpc_ram_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int N_CFG       = 12;  // Bank/scheme values in the read sweep
  localparam int N_WR        = 10;  // Writes in the length test
  localparam int MAX_K       = 7;   // Longest READY stall
  localparam int SWEEP       = 20;  // Cycles for one quadrant sweep
  localparam int PLAN_CYCLES = 20 + 6 * (2 + SWEEP) + N_CFG * (2 + SWEEP) + 10
                               + N_WR * (MAX_K + 8) + 3 * (MAX_K + 8);
  localparam int WATCHDOG_NS = (PLAN_CYCLES + 200) * CLK_PERIOD;

  logic clk;
  logic reset_b;
  logic mreq_b;
  logic iorq_b;
  logic rfsh_b;
  logic wr_b;
  logic rd_b;
  logic ramrd_b;
  logic ready;
  logic adr15;
  logic adr14;
  logic [7:0] data;
  logic ramdis;
  logic ramcs_b;
  logic [RAM_ADR_W-1:0] ramadrhi;
  logic ramoe_b;
  logic ramwe_b;
  logic rd_force;
  logic adr15_force;

  bank_cfg_t   model_cfg;  // Reference copy of the bank register
  logic        model_lat;  // Reference copy of latched A15
  logic [31:0] rng;
  int          err_cnt;
  int          n_checks;

  ram512k_top u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Mapping rules per scheme and quadrant
  function automatic void map_ref(input bank_cfg_t cfg, input logic [1:0] q, input logic wr_n,
                                  output logic cs_b, output logic hit,
                                  output logic [RAM_ADR_W-1:0] adr);
    logic [2:0] b;
    logic [1:0] blk;
    logic       c3_shadow;
    b = (cfg.bank == 3'd7) ? 3'd6 : cfg.bank;  // Shadow bank aliases down
    c3_shadow = 1'b0;
    case (cfg.scheme)
      SCH_HI_BLOCK: hit = (q == 2'd3);
      SCH_FLAT:     hit = 1'b1;
      SCH_C3: begin
        hit       = (q == 2'd3);
        c3_shadow = (q == 2'd1);
      end
      SCH_LO_B0, SCH_LO_B1, SCH_LO_B2, SCH_LO_B3: hit = (q == 2'd1);
      default:      hit = 1'b0;
    endcase
    case (cfg.scheme)
      SCH_FLAT:  blk = q;
      SCH_LO_B0: blk = 2'd0;
      SCH_LO_B1: blk = 2'd1;
      SCH_LO_B2: blk = 2'd2;
      SCH_LO_B3: blk = 2'd3;
      default:   blk = 2'd3;  // High block and C3
    endcase
    if (hit) begin
      cs_b = 1'b0;
      adr  = {b, blk};
    end else if (c3_shadow) begin
      cs_b = 1'b0;
      adr  = {SHADOW_BANK, 2'd3};
    end else begin
      cs_b = !(!wr_n && (q == 2'd3));  // Top quadrant writes go to shadow
      adr  = {SHADOW_BANK, q};
    end
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_adr(input logic [RAM_ADR_W-1:0] got, input logic [RAM_ADR_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: ramadrhi is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_len(input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      err_cnt++;
      $display("Fail at %0t: write window %0d cycles, expected %0d", $time, got, exp);
    end
  endtask

  task automatic io_write(input logic a15, input logic iorq_n, input logic [7:0] dat);
    @(negedge clk);
    iorq_b = iorq_n;
    wr_b   = 1'b0;
    adr15  = a15;
    data   = dat;
    if (!iorq_n && !a15 && (dat[7:6] == 2'b11)) begin
      model_cfg.bank   = dat[5:3];
      model_cfg.scheme = map_scheme_e'(dat[2:0]);
    end
    @(negedge clk);
    iorq_b = 1'b1;
    wr_b   = 1'b1;
  endtask

  // Memory read, no cycle start so A15 stays as latched
  task automatic read_access(input logic a14);
    logic cs_b;
    logic hit;
    logic [RAM_ADR_W-1:0] adr;
    @(negedge clk);
    mreq_b  = 1'b0;
    rd_b    = 1'b0;
    ramrd_b = 1'b0;
    adr15   = !model_lat;  // Live A15 differs, mapping must use the latch
    adr14   = a14;
    @(posedge clk);
    #1;
    map_ref(model_cfg, {model_lat, a14}, 1'b1, cs_b, hit, adr);
    check_bit("ramcs_b", ramcs_b, cs_b);
    check_bit("ramdis", ramdis, !cs_b);
    check_adr(ramadrhi, adr);
    check_bit("ramoe_b", ramoe_b, 1'b0);  // Follows ramrd_b
    check_bit("rd_force", rd_force, 1'b0);
    @(negedge clk);
    mreq_b  = 1'b1;
    rd_b    = 1'b1;
    ramrd_b = 1'b1;
  endtask

  // Memory write stalled by k READY low edges, window tracked on ramoe_b
  task automatic write_cycle(input logic a15, input logic a14, input int k);
    logic cs_b;
    logic hit;
    logic [RAM_ADR_W-1:0] adr;
    int n;
    @(negedge clk);
    mreq_b    = 1'b0;
    rd_b      = 1'b1;
    ramrd_b   = 1'b0;  // ramoe_b then shows the write window only
    adr15     = a15;
    adr14     = a14;
    ready     = (k > 0) ? 1'b0 : 1'b1;
    model_lat = a15;
    n = 0;
    @(posedge clk);
    #1;
    while (ramoe_b === 1'b1 && n < k + 10) begin
      map_ref(model_cfg, {a15, a14}, wr_b, cs_b, hit, adr);
      check_bit("ramcs_b", ramcs_b, cs_b);
      check_bit("ramdis", ramdis, !cs_b);
      check_bit("ramwe_b", ramwe_b, wr_b);
      check_adr(ramadrhi, adr);
      check_bit("rd_force", rd_force, hit);
      check_bit("adr15_force", adr15_force, (model_cfg.scheme == SCH_C3) && !a15 && a14);
      n++;
      @(negedge clk);
      wr_b  = 1'b0;                      // WR falls a cycle after MREQ
      ready = (n < k) ? 1'b0 : 1'b1;
      @(posedge clk);
      #1;
    end
    check_len(n, k + 2);
    check_bit("rd_force", rd_force, 1'b0);
    check_bit("adr15_force", adr15_force, 1'b0);
    @(negedge clk);
    mreq_b  = 1'b1;
    wr_b    = 1'b1;
    ramrd_b = 1'b1;
    ready   = 1'b1;
  endtask

  // Latch each A15 value with a write, then read both quadrants
  task automatic sweep_quadrants();
    logic [31:0] r;
    for (int lat = 0; lat < 2; lat++) begin
      r = next_rand();
      write_cycle(lat[0], 1'b1, int'(r[1:0]));
      read_access(1'b0);
      read_access(1'b1);
    end
  endtask

  task automatic after_reset();
    check_bit("rd_force", rd_force, 1'b0);
    check_bit("adr15_force", adr15_force, 1'b0);
    check_bit("ramcs_b", ramcs_b, 1'b1);  // Bus idle
    sweep_quadrants();                    // Base scheme, bank 0
  endtask

  task automatic bank_register();
    io_write(1'b0, 1'b0, 8'b11_010_010);  // Bank 2, flat
    sweep_quadrants();
    io_write(1'b1, 1'b0, 8'b11_101_001);  // A15 high
    sweep_quadrants();
    io_write(1'b0, 1'b0, 8'b10_101_001);  // Wrong tag
    sweep_quadrants();
    io_write(1'b0, 1'b1, 8'b11_101_001);  // No IORQ
    sweep_quadrants();
    io_write(1'b0, 1'b0, 8'b11_111_011);  // Bank 7, C3
    sweep_quadrants();
  endtask

  task automatic read_mapping();
    logic [31:0] r;
    logic [2:0]  bank;
    for (int i = 0; i < N_CFG; i++) begin
      r = next_rand();
      bank = (i % 4 == 0) ? 3'd7 : r[2:0];
      io_write(1'b0, 1'b0, {2'b11, bank, 3'(i)});  // Every scheme at least once
      sweep_quadrants();
    end
  endtask

  task automatic refresh_cycles();
    logic [31:0] r;
    r = next_rand();
    io_write(1'b0, 1'b0, 8'b11_001_010);  // Flat would select every quadrant
    @(negedge clk);
    mreq_b  = 1'b0;
    rfsh_b  = 1'b0;
    ramrd_b = 1'b0;
    adr15   = r[0];
    adr14   = r[1];
    repeat (4) begin
      @(posedge clk);
      #1;
      check_bit("ramcs_b", ramcs_b, 1'b1);
      check_bit("ramoe_b", ramoe_b, 1'b0);  // No write window
      check_bit("rd_force", rd_force, 1'b0);
    end
    @(negedge clk);
    mreq_b  = 1'b1;
    rfsh_b  = 1'b1;
    ramrd_b = 1'b1;
  endtask

  task automatic write_length();
    logic [31:0] r;
    for (int i = 0; i < N_WR; i++) begin
      r = next_rand();
      io_write(1'b0, 1'b0, {2'b11, r[5:3], i[0] ? 3'b010 : r[2:0]});  // Odd ones flat
      write_cycle(r[8], r[9], int'(r[14:12]));
    end
  endtask

  task automatic mode_c3_writes();
    io_write(1'b0, 1'b0, {2'b11, 3'd7, SCH_C3});
    write_cycle(1'b0, 1'b1, 2);  // 0x4000, overdrive to shadow block 3
    write_cycle(1'b1, 1'b1, 1);  // 0xC000, bank 6 block 3
    io_write(1'b0, 1'b0, {2'b11, 3'd5, SCH_C3});
    write_cycle(1'b1, 1'b1, 0);
  endtask

  initial begin
    clk       = 1'b0;
    reset_b   = 1'b0;
    mreq_b    = 1'b1;
    iorq_b    = 1'b1;
    rfsh_b    = 1'b1;
    wr_b      = 1'b1;
    rd_b      = 1'b1;
    ramrd_b   = 1'b1;
    ready     = 1'b1;
    adr15     = 1'b0;
    adr14     = 1'b0;
    data      = 8'h00;
    model_cfg = '0;
    model_lat = 1'b0;
    rng       = 32'h98d2f395;
    err_cnt   = 0;
    n_checks  = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;
    @(posedge clk);
    #1;
    after_reset();
    bank_register();
    read_mapping();
    refresh_cycles();
    write_length();
    mode_c3_writes();
    $display("%0d checks, %0d errors", n_checks, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog sized from the planned cycle count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns, %0d errors so far", WATCHDOG_NS,
             err_cnt);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
cpc_ram_pkg.sv
bank_select_reg.sv
write_cycle_ctrl.sv
ram_mapper.sv
ram512k_top.sv
tb_ram512k.sv

// ==== Bender.yml ====
package:
  name: ram512k

sources:
  - cpc_ram_pkg.sv
  - bank_select_reg.sv
  - write_cycle_ctrl.sv
  - ram_mapper.sv
  - ram512k_top.sv
  - target: test
    files:
      - tb_ram512k.sv
